// ==== logic/tank_pkg.sv ====
package tank_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [4:0] btns_t;
    typedef logic [7:0] pixel_t;

    typedef enum logic [1:0]
    {
        DIR_UP    = 2'b00,
        DIR_DOWN  = 2'b01,
        DIR_LEFT  = 2'b10,
        DIR_RIGHT = 2'b11
    } dir_t;

    typedef enum logic [1:0]
    {
        WIN_NONE  = 2'b00,
        WIN_RED   = 2'b01,
        WIN_GREEN = 2'b10
    } winner_t;

    // One-hot button codes, only an exact match is a command
    localparam btns_t BTN_UP    = 5'b00001;
    localparam btns_t BTN_DOWN  = 5'b00010;
    localparam btns_t BTN_LEFT  = 5'b00100;
    localparam btns_t BTN_RIGHT = 5'b01000;
    localparam btns_t BTN_FIRE  = 5'b10000;

    // Sprite boxes
    localparam int TANK_SIZE   = 32;
    localparam int SHOT_LONG   = 16;
    localparam int SHOT_SHORT  = 8;
    localparam int SHOT_OFFSET = 15;

    localparam int FIELD_W = 640;
    localparam int FIELD_H = 480;

    // RGB332 colours
    localparam pixel_t COLOR_BG    = 8'hFF;
    localparam pixel_t COLOR_RED   = 8'hE0;
    localparam pixel_t COLOR_GREEN = 8'h1C;
    localparam pixel_t COLOR_SHOT  = 8'h00;

endpackage

// ==== logic/tank_unit.sv ====
`timescale 1ns/1ps

module tank_unit #(
    parameter int               MOVE_DIV  = 100000,
    parameter int               SHOT_DIV  = 25000,
    parameter tank_pkg::coord_t START_X   = 10'd0,
    parameter tank_pkg::coord_t START_Y   = 10'd0,
    parameter tank_pkg::dir_t   START_DIR = tank_pkg::DIR_UP
) (
    input  logic             clk_25m,
    input  logic             rst_n,
    input  tank_pkg::btns_t  btns,
    input  logic             frozen,
    output tank_pkg::coord_t tank_x,
    output tank_pkg::coord_t tank_y,
    output tank_pkg::dir_t   tank_dir,
    output logic             shot_live,
    output tank_pkg::coord_t shot_x,
    output tank_pkg::coord_t shot_y,
    output tank_pkg::dir_t   shot_dir
);

    import tank_pkg::*;

    localparam int CNT_W = $clog2(((MOVE_DIV > SHOT_DIV) ? MOVE_DIV : SHOT_DIV) + 1);

    logic [1:0] tick;
    logic       move_tick;
    logic       shot_tick;
    logic       dir_cmd;
    dir_t       cmd_dir;
    logic       fire_cmd;
    logic       shot_out;

    // One pixel step, coordinates wrap modulo 1024
    function automatic logic [19:0] step_xy(coord_t x, coord_t y, dir_t d);
        coord_t nx;
        coord_t ny;
        nx = x;
        ny = y;
        case (d)
            DIR_UP:    ny = y - 10'd1;
            DIR_DOWN:  ny = y + 10'd1;
            DIR_LEFT:  nx = x - 10'd1;
            default:   nx = x + 10'd1;
        endcase
        return {nx, ny};
    endfunction

    ////////////////////////////////
    // Tick dividers
    ////////////////////////////////

    // tick[0] moves the tank, tick[1] moves the bullet
    for (genvar i = 0; i < 2; i++)
    begin : g_tick
        localparam int DIV = (i == 0) ? MOVE_DIV : SHOT_DIV;

        logic [CNT_W-1:0] cnt;

        always_ff @(posedge clk_25m or negedge rst_n)
        begin
            if (!rst_n)
            begin
                cnt     <= '0;
                tick[i] <= 1'b0;
            end
            else if (cnt == CNT_W'(DIV - 1))
            begin
                cnt     <= '0;
                tick[i] <= 1'b1;
            end
            else
            begin
                cnt     <= cnt + 1'b1;
                tick[i] <= 1'b0;
            end
        end
    end

    assign move_tick = tick[0];
    assign shot_tick = tick[1];

    ////////////////////////////////
    // Button decode
    ////////////////////////////////

    always_comb
    begin
        dir_cmd = 1'b1;
        cmd_dir = tank_dir;
        case (btns)
            BTN_UP:    cmd_dir = DIR_UP;
            BTN_DOWN:  cmd_dir = DIR_DOWN;
            BTN_LEFT:  cmd_dir = DIR_LEFT;
            BTN_RIGHT: cmd_dir = DIR_RIGHT;
            default:   dir_cmd = 1'b0;
        endcase
    end

    assign fire_cmd = (btns == BTN_FIRE) && !shot_live && !frozen;
    assign shot_out = (shot_x >= coord_t'(FIELD_W)) || (shot_y >= coord_t'(FIELD_H));

    ////////////////////////////////
    // Tank and bullet state
    ////////////////////////////////

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tank_x    <= START_X;
            tank_y    <= START_Y;
            tank_dir  <= START_DIR;
            shot_live <= 1'b0;
        end
        else
        begin
            if (dir_cmd && !frozen)
                tank_dir <= cmd_dir;
            if (dir_cmd && !frozen && move_tick)
                {tank_x, tank_y} <= step_xy(tank_x, tank_y, cmd_dir);
            // Launch, then retire once the origin is off the field
            if (fire_cmd)
                shot_live <= 1'b1;
            else if (shot_live && shot_out)
                shot_live <= 1'b0;
        end
    end

    always_ff @(posedge clk_25m)
    begin
        if (fire_cmd)
        begin
            shot_x   <= tank_x + coord_t'(SHOT_OFFSET);
            shot_y   <= tank_y + coord_t'(SHOT_OFFSET);
            shot_dir <= tank_dir;
        end
        else if (shot_live && shot_tick && !frozen)
            {shot_x, shot_y} <= step_xy(shot_x, shot_y, shot_dir);
    end

endmodule

// ==== logic/arena_mixer.sv ====
`timescale 1ns/1ps

module arena_mixer (
    input  logic              clk_25m,
    input  logic              rst_n,
    input  tank_pkg::coord_t  pixel_x,
    input  tank_pkg::coord_t  pixel_y,
    input  tank_pkg::coord_t  red_tank_x,
    input  tank_pkg::coord_t  red_tank_y,
    input  tank_pkg::dir_t    red_tank_dir,
    input  logic              red_shot_live,
    input  tank_pkg::coord_t  red_shot_x,
    input  tank_pkg::coord_t  red_shot_y,
    input  tank_pkg::dir_t    red_shot_dir,
    input  tank_pkg::coord_t  green_tank_x,
    input  tank_pkg::coord_t  green_tank_y,
    input  tank_pkg::dir_t    green_tank_dir,
    input  logic              green_shot_live,
    input  tank_pkg::coord_t  green_shot_x,
    input  tank_pkg::coord_t  green_shot_y,
    input  tank_pkg::dir_t    green_shot_dir,
    output tank_pkg::pixel_t  screen_data,
    output tank_pkg::winner_t winner,
    output logic              frozen
);

    import tank_pkg::*;

    logic   red_hit;
    logic   green_hit;
    pixel_t pixel_next;

    // Inclusive box, far edge kept in 11 bits so it cannot wrap
    function automatic logic in_box(coord_t px, coord_t py, coord_t ox, coord_t oy,
                                    int w, int h);
        logic [10:0] x_end;
        logic [10:0] y_end;
        x_end = {1'b0, ox} + 11'(w - 1);
        y_end = {1'b0, oy} + 11'(h - 1);
        return (px >= ox) && ({1'b0, px} <= x_end) && (py >= oy) && ({1'b0, py} <= y_end);
    endfunction

    // Bullet is tall when heading up or down
    function automatic logic on_shot(coord_t px, coord_t py, logic live,
                                     coord_t sx, coord_t sy, dir_t d);
        logic vert;
        vert = (d == DIR_UP) || (d == DIR_DOWN);
        return live && in_box(px, py, sx, sy, vert ? SHOT_SHORT : SHOT_LONG,
                              vert ? SHOT_LONG : SHOT_SHORT);
    endfunction

    ////////////////////////////////
    // Hits and winner
    ////////////////////////////////

    assign red_hit   = red_shot_live &&
                       in_box(red_shot_x, red_shot_y, green_tank_x, green_tank_y,
                              TANK_SIZE, TANK_SIZE);
    assign green_hit = green_shot_live &&
                       in_box(green_shot_x, green_shot_y, red_tank_x, red_tank_y,
                              TANK_SIZE, TANK_SIZE);

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            winner <= WIN_NONE;
        else if (winner == WIN_NONE)
        begin
            // Red takes a simultaneous hit
            if (red_hit)
                winner <= WIN_RED;
            else if (green_hit)
                winner <= WIN_GREEN;
        end
    end

    assign frozen = (winner != WIN_NONE);

    ////////////////////////////////
    // Pixel colour
    ////////////////////////////////

    // Bullets on top, then green tank over red tank
    always_comb
    begin
        if (on_shot(pixel_x, pixel_y, green_shot_live, green_shot_x, green_shot_y,
                    green_shot_dir) ||
            on_shot(pixel_x, pixel_y, red_shot_live, red_shot_x, red_shot_y,
                    red_shot_dir))
            pixel_next = COLOR_SHOT;
        else if (in_box(pixel_x, pixel_y, green_tank_x, green_tank_y, TANK_SIZE, TANK_SIZE))
            pixel_next = COLOR_GREEN;
        else if (in_box(pixel_x, pixel_y, red_tank_x, red_tank_y, TANK_SIZE, TANK_SIZE))
            pixel_next = COLOR_RED;
        else
            pixel_next = COLOR_BG;
    end

    always_ff @(posedge clk_25m or negedge rst_n)
    begin
        if (!rst_n)
            screen_data <= COLOR_BG;
        else
            screen_data <= pixel_next;
    end

endmodule

// ==== logic/tank_arena.sv ====
`timescale 1ns/1ps

module tank_arena #(
    parameter int MOVE_DIV = 100000,
    parameter int SHOT_DIV = 25000
) (
    input  logic              clk_25m,
    input  logic              rst_n,
    input  tank_pkg::coord_t  pixel_x,
    input  tank_pkg::coord_t  pixel_y,
    input  tank_pkg::btns_t   red_btns,
    input  tank_pkg::btns_t   green_btns,
    output tank_pkg::pixel_t  screen_data,
    output tank_pkg::winner_t winner
);

    import tank_pkg::*;

    coord_t red_tank_x;
    coord_t red_tank_y;
    dir_t   red_tank_dir;
    logic   red_shot_live;
    coord_t red_shot_x;
    coord_t red_shot_y;
    dir_t   red_shot_dir;

    coord_t green_tank_x;
    coord_t green_tank_y;
    dir_t   green_tank_dir;
    logic   green_shot_live;
    coord_t green_shot_x;
    coord_t green_shot_y;
    dir_t   green_shot_dir;

    logic   frozen;

    ////////////////////////////////
    // Players
    ////////////////////////////////

    // Red starts top left facing down
    tank_unit #(
        .MOVE_DIV  (MOVE_DIV),
        .SHOT_DIV  (SHOT_DIV),
        .START_X   (10'd70),
        .START_Y   (10'd50),
        .START_DIR (DIR_DOWN)
    ) red_unit (
        .clk_25m   (clk_25m),
        .rst_n     (rst_n),
        .btns      (red_btns),
        .frozen    (frozen),
        .tank_x    (red_tank_x),
        .tank_y    (red_tank_y),
        .tank_dir  (red_tank_dir),
        .shot_live (red_shot_live),
        .shot_x    (red_shot_x),
        .shot_y    (red_shot_y),
        .shot_dir  (red_shot_dir)
    );

    // Green starts bottom right facing up
    tank_unit #(
        .MOVE_DIV  (MOVE_DIV),
        .SHOT_DIV  (SHOT_DIV),
        .START_X   (10'd530),
        .START_Y   (10'd400),
        .START_DIR (DIR_UP)
    ) green_unit (
        .clk_25m   (clk_25m),
        .rst_n     (rst_n),
        .btns      (green_btns),
        .frozen    (frozen),
        .tank_x    (green_tank_x),
        .tank_y    (green_tank_y),
        .tank_dir  (green_tank_dir),
        .shot_live (green_shot_live),
        .shot_x    (green_shot_x),
        .shot_y    (green_shot_y),
        .shot_dir  (green_shot_dir)
    );

    ////////////////////////////////
    // Hits and pixels
    ////////////////////////////////

    arena_mixer mixer (
        .clk_25m         (clk_25m),
        .rst_n           (rst_n),
        .pixel_x         (pixel_x),
        .pixel_y         (pixel_y),
        .red_tank_x      (red_tank_x),
        .red_tank_y      (red_tank_y),
        .red_tank_dir    (red_tank_dir),
        .red_shot_live   (red_shot_live),
        .red_shot_x      (red_shot_x),
        .red_shot_y      (red_shot_y),
        .red_shot_dir    (red_shot_dir),
        .green_tank_x    (green_tank_x),
        .green_tank_y    (green_tank_y),
        .green_tank_dir  (green_tank_dir),
        .green_shot_live (green_shot_live),
        .green_shot_x    (green_shot_x),
        .green_shot_y    (green_shot_y),
        .green_shot_dir  (green_shot_dir),
        .screen_data     (screen_data),
        .winner          (winner),
        .frozen          (frozen)
    );

endmodule

// ==== tests/tank_arena_chk.sv ====
`timescale 1ns/1ps

module tank_arena_chk (
    input logic              clk_25m,
    input logic              rst_n,
    input tank_pkg::winner_t winner,
    input logic              frozen,
    input tank_pkg::coord_t  red_tank_x,
    input tank_pkg::coord_t  red_tank_y,
    input tank_pkg::dir_t    red_tank_dir,
    input logic              red_shot_live,
    input tank_pkg::coord_t  red_shot_x,
    input tank_pkg::coord_t  red_shot_y,
    input tank_pkg::coord_t  green_tank_x,
    input tank_pkg::coord_t  green_tank_y,
    input tank_pkg::dir_t    green_tank_dir,
    input logic              green_shot_live,
    input tank_pkg::coord_t  green_shot_x,
    input tank_pkg::coord_t  green_shot_y
);

    import tank_pkg::*;

    int fail_count = 0;

    // Winner stays latched until reset
    winner_held: assert property (@(posedge clk_25m) disable iff (!rst_n)
        (winner != WIN_NONE) |=> $stable(winner))
    else
    begin
        fail_count++;
        $error("winner changed after it was latched");
    end

    // Frozen tanks keep place and heading
    tanks_frozen: assert property (@(posedge clk_25m) disable iff (!rst_n)
        frozen |=> $stable({red_tank_x, red_tank_y, red_tank_dir,
                            green_tank_x, green_tank_y, green_tank_dir}))
    else
    begin
        fail_count++;
        $error("a tank moved or turned while frozen");
    end

    shots_frozen: assert property (@(posedge clk_25m) disable iff (!rst_n)
        frozen |=> (!$past(red_shot_live) || $stable({red_shot_x, red_shot_y}))
                && (!$past(green_shot_live) || $stable({green_shot_x, green_shot_y})))
    else
    begin
        fail_count++;
        $error("a live bullet moved while frozen");
    end

endmodule

bind arena_mixer tank_arena_chk mixer_chk (
    .clk_25m         (clk_25m),
    .rst_n           (rst_n),
    .winner          (winner),
    .frozen          (frozen),
    .red_tank_x      (red_tank_x),
    .red_tank_y      (red_tank_y),
    .red_tank_dir    (red_tank_dir),
    .red_shot_live   (red_shot_live),
    .red_shot_x      (red_shot_x),
    .red_shot_y      (red_shot_y),
    .green_tank_x    (green_tank_x),
    .green_tank_y    (green_tank_y),
    .green_tank_dir  (green_tank_dir),
    .green_shot_live (green_shot_live),
    .green_shot_x    (green_shot_x),
    .green_shot_y    (green_shot_y)
);

// ==== tests/tank_arena_tb.sv ====
`timescale 1ns/1ps

module tank_arena_tb;

    import tank_pkg::*;

    localparam int    NUM_ROWS   = 19;
    localparam int    CLK_PERIOD = 40;
    localparam btns_t NO_BTN     = 5'b00000;

    logic    clk_25m;
    logic    rst_n;
    coord_t  pixel_x;
    coord_t  pixel_y;
    btns_t   red_btns;
    btns_t   green_btns;
    pixel_t  screen_data;
    winner_t winner;

    // One row per step, probed after the hold
    btns_t   red_tab   [NUM_ROWS];
    btns_t   green_tab [NUM_ROWS];
    int      hold_tab  [NUM_ROWS];
    coord_t  px_tab    [NUM_ROWS];
    coord_t  py_tab    [NUM_ROWS];
    pixel_t  color_tab [NUM_ROWS];
    winner_t win_tab   [NUM_ROWS];
    int      row_count;
    integer  seed;

    tank_arena #(
        .MOVE_DIV (8),
        .SHOT_DIV (2)
    ) UUT (
        .clk_25m     (clk_25m),
        .rst_n       (rst_n),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .red_btns    (red_btns),
        .green_btns  (green_btns),
        .screen_data (screen_data),
        .winner      (winner)
    );

    ////////////////////////////////
    // Table and checks
    ////////////////////////////////

    task automatic add_row(input btns_t red, input btns_t green, input int hold,
                           input int px, input int py, input pixel_t color,
                           input winner_t win);
        red_tab[row_count]   = red;
        green_tab[row_count] = green;
        hold_tab[row_count]  = hold;
        px_tab[row_count]    = coord_t'(px);
        py_tab[row_count]    = coord_t'(py);
        color_tab[row_count] = color;
        win_tab[row_count]   = win;
        row_count++;
    endtask

    // Move ticks land on edges 8n+1 after reset, shot ticks on odd edges from 3
    task automatic load_table();
        row_count = 0;
        add_row(NO_BTN, NO_BTN, 2, 70, 50, COLOR_RED, WIN_NONE);
        add_row(NO_BTN, NO_BTN, 1, 530, 400, COLOR_GREEN, WIN_NONE);
        // 32 cycles hold four move ticks
        add_row(BTN_RIGHT, NO_BTN, 32, 74, 50, COLOR_RED, WIN_NONE);
        add_row(NO_BTN, NO_BTN, 2, 73, 50, COLOR_BG, WIN_NONE);
        // Turn up on a cycle without a move tick
        add_row(BTN_UP, NO_BTN, 1, 74, 50, COLOR_RED, WIN_NONE);
        add_row(BTN_FIRE, NO_BTN, 1, 89, 65, COLOR_SHOT, WIN_NONE);
        add_row(NO_BTN, NO_BTN, 1, 96, 65, COLOR_SHOT, WIN_NONE);
        // Bullet wraps past y 0 and retires
        add_row(NO_BTN, NO_BTN, 140, 89, 10, COLOR_BG, WIN_NONE);
        add_row(BTN_FIRE, NO_BTN, 1, 89, 65, COLOR_SHOT, WIN_NONE);
        // 221 steps each put green under red's gun
        add_row(BTN_RIGHT, BTN_LEFT, 1768, 295, 50, COLOR_RED, WIN_NONE);
        add_row(NO_BTN, NO_BTN, 1, 309, 400, COLOR_GREEN, WIN_NONE);
        add_row(BTN_DOWN, NO_BTN, 1, 295, 50, COLOR_RED, WIN_NONE);
        add_row(BTN_FIRE, NO_BTN, 1, 310, 65, COLOR_SHOT, WIN_NONE);
        // 300 steps down, origin at y 366
        add_row(NO_BTN, NO_BTN, 600, 310, 366, COLOR_SHOT, WIN_NONE);
        add_row(NO_BTN, NO_BTN, 100, 309, 400, COLOR_GREEN, WIN_RED);
        // Frozen, so the far edges of both boxes stay put
        add_row(BTN_LEFT, BTN_UP, 16, 326, 50, COLOR_RED, WIN_RED);
        add_row(NO_BTN, NO_BTN, 1, 309, 431, COLOR_GREEN, WIN_RED);
        add_row(BTN_FIRE, BTN_FIRE, 4, 324, 415, COLOR_GREEN, WIN_RED);
        add_row(NO_BTN, NO_BTN, 1, 310, 400, COLOR_SHOT, WIN_RED);
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pixel(input string what, input pixel_t got, input pixel_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s screen_data = %h, expected %h", what, got, exp));
    endtask

    task automatic check_winner(input string what, input winner_t got, input winner_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s winner = %h, expected %h", what, got, exp));
    endtask

    // Left middle area, never crossed by a tank or bullet
    task automatic pick_background();
        pixel_x = coord_t'($unsigned($random(seed)) % 200);
        pixel_y = coord_t'(100 + $unsigned($random(seed)) % 280);
    endtask

    task automatic apply_row(input int i);
        red_btns   = red_tab[i];
        green_btns = green_tab[i];
        pick_background();
        repeat (hold_tab[i])
        begin
            @(posedge clk_25m);
            #1;
        end
        check_pixel($sformatf("row %0d idle (%0d,%0d)", i, pixel_x, pixel_y),
                    screen_data, COLOR_BG);
        red_btns   = NO_BTN;
        green_btns = NO_BTN;
        pixel_x    = px_tab[i];
        pixel_y    = py_tab[i];
        @(posedge clk_25m);
        #1;
        check_pixel($sformatf("row %0d probe (%0d,%0d)", i, pixel_x, pixel_y),
                    screen_data, color_tab[i]);
        check_winner($sformatf("row %0d", i), winner, win_tab[i]);
    endtask

    ////////////////////////////////
    // Clock, reset and sequence
    ////////////////////////////////

    initial
    begin
        clk_25m = 1'b0;
        forever #(CLK_PERIOD / 2) clk_25m = ~clk_25m;
    end

    initial
    begin : stimulus
        seed       = 32'hc21a699a;
        rst_n      = 1'b0;
        red_btns   = NO_BTN;
        green_btns = NO_BTN;
        pixel_x    = '0;
        pixel_y    = '0;
        load_table();
        repeat (16) @(posedge clk_25m);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < row_count; i++)
            apply_row(i);
        if (UUT.mixer.mixer_chk.fail_count == 0)
        begin
            $display("Done: no errors");
            $finish;
        end
        else
            abort_run("A bound assertion failed during the run");
    end

    always @(posedge clk_25m)
    begin
        if (UUT.mixer.mixer_chk.fail_count != 0)
            abort_run("A bound assertion failed");
    end

    initial
    begin : watchdog
        longint budget;
        @(posedge rst_n);
        budget = 200;
        for (int i = 0; i < row_count; i++)
            budget += hold_tab[i];
        #(budget * CLK_PERIOD);
        abort_run("Watchdog timeout: the test sequence did not complete in time");
    end

endmodule

// ==== src.f ====
logic/tank_pkg.sv
logic/tank_unit.sv
logic/arena_mixer.sv
logic/tank_arena.sv
tests/tank_arena_chk.sv
tests/tank_arena_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tank_arena_tb \
    -o tank_arena_sim
status=0
./obj_dir/tank_arena_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Done: errors found" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Done: no errors" sim.log; then
    exit 1
fi
